// ==== design/des_defs.svh ====
// width macros for the DES data path and key schedule
// round count and pipeline depth

`ifndef DES_DEFS_SVH
`define DES_DEFS_SVH

// ==================================================
// data path widths
// ==================================================
`define DES_BLOCK_W  64
`define DES_HALF_W   32

// key schedule widths
// key input still carries the eight parity bits
`define DES_KEY_W    64
`define DES_CD_W     28
`define DES_SUBKEY_W 48

// ==================================================
// pipeline shape
// ==================================================
`define DES_ROUNDS   16
// input stage, one stage per round, output stage
`define DES_LATENCY  (`DES_ROUNDS + 2)

`endif

// ==== design/des_pkg.sv ====
// DES types, mode enumeration and permutation tables
// table functions for IP, FP, PC1, PC2, E and P
// S-box lookup, Feistel function and key rotation schedule

`include "des_defs.svh"

package des_pkg;

    // ascending ranges, index 0 is bit 1 of the standard
    typedef logic [0:`DES_BLOCK_W-1]  block_t;
    typedef logic [0:`DES_HALF_W-1]   half_t;
    typedef logic [0:`DES_CD_W-1]     cd_t;
    typedef logic [0:`DES_SUBKEY_W-1] subkey_t;

    typedef enum logic {
        DES_ENCRYPT = 1'b0,
        DES_DECRYPT = 1'b1
    } des_mode_e;

    // ==================================================
    // permutation tables, 1-based as in the standard
    // ==================================================
    localparam byte unsigned IP_TAB [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2,
        60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6,
        64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1,
        59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5,
        63, 55, 47, 39, 31, 23, 15, 7
    };

    // inverse of IP
    localparam byte unsigned FP_TAB [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32,
        39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30,
        37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28,
        35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26,
        33, 1, 41,  9, 49, 17, 57, 25
    };

    // key permutation, parity bits dropped
    localparam byte unsigned PC1_C_TAB [28] = '{
        57, 49, 41, 33, 25, 17,  9,
         1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27,
        19, 11,  3, 60, 52, 44, 36
    };

    localparam byte unsigned PC1_D_TAB [28] = '{
        63, 55, 47, 39, 31, 23, 15,
         7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29,
        21, 13,  5, 28, 20, 12,  4
    };

    // selects 48 of the 56 C/D bits
    localparam byte unsigned PC2_TAB [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28,
        15,  6, 21, 10, 23, 19, 12,  4,
        26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56,
        34, 53, 46, 42, 50, 36, 29, 32
    };

    localparam byte unsigned P_TAB [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,
         1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9,
        19, 13, 30,  6, 22, 11,  4, 25
    };

    // ==================================================
    // S-boxes, 4 rows of 16 nibbles, first entry on top
    // ==================================================
    localparam logic [255:0] SBOX_TAB [8] = '{
        {64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
         64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D},
        {64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
         64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9},
        {64'hA09E63F51DC7B428, 64'hD709346A285ECBF1,
         64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C},
        {64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
         64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E},
        {64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
         64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453},
        {64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
         64'h9EF528C3704A1DB6, 64'h432C95FABE17608D},
        {64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
         64'h14BDC37EAF680592, 64'h6BD814A7950FE23C},
        {64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
         64'h7B419CE206ADF358, 64'h21E74A8DFC90356B}
    };

    // ==================================================
    // table functions
    // ==================================================
    function automatic block_t ip_perm(input block_t d);
        block_t p;
        for (int i = 0; i < 64; i++) begin
            p[i] = d[IP_TAB[i] - 1];
        end
        return p;
    endfunction

    function automatic block_t fp_perm(input block_t d);
        block_t p;
        for (int i = 0; i < 64; i++) begin
            p[i] = d[FP_TAB[i] - 1];
        end
        return p;
    endfunction

    function automatic cd_t pc1_c(input logic [0:`DES_KEY_W-1] key);
        cd_t c;
        for (int i = 0; i < `DES_CD_W; i++) begin
            c[i] = key[PC1_C_TAB[i] - 1];
        end
        return c;
    endfunction

    function automatic cd_t pc1_d(input logic [0:`DES_KEY_W-1] key);
        cd_t d;
        for (int i = 0; i < `DES_CD_W; i++) begin
            d[i] = key[PC1_D_TAB[i] - 1];
        end
        return d;
    endfunction

    function automatic subkey_t pc2_perm(input cd_t c, input cd_t d);
        logic [0:2*`DES_CD_W-1] cd;
        subkey_t k;
        cd = {c, d};
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            k[i] = cd[PC2_TAB[i] - 1];
        end
        return k;
    endfunction

    // each 6-bit group is the 4-bit nibble plus one neighbor on each side
    function automatic subkey_t e_expand(input half_t r);
        subkey_t e;
        for (int i = 0; i < 8; i++) begin
            e[6*i +: 6] = {r[(4*i + 31) % 32], r[4*i +: 4], r[(4*i + 4) % 32]};
        end
        return e;
    endfunction

    function automatic half_t p_perm(input half_t s);
        half_t p;
        for (int i = 0; i < 32; i++) begin
            p[i] = s[P_TAB[i] - 1];
        end
        return p;
    endfunction

    // outer bits pick the row, inner four the column
    function automatic logic [3:0] sbox(input int unsigned n, input logic [0:5] x);
        int unsigned idx;
        idx = {x[0], x[5], x[1:4]};
        return SBOX_TAB[n][255 - 4*idx -: 4];
    endfunction

    function automatic half_t feistel_f(input half_t r, input subkey_t k);
        subkey_t x;
        half_t s;
        x = e_expand(r) ^ k;
        for (int i = 0; i < 8; i++) begin
            s[4*i +: 4] = sbox(i, x[6*i +: 6]);
        end
        return p_perm(s);
    endfunction

    // rotation of C and D before a round
    // positive is left for encryption, negative is right for decryption
    function automatic int round_shift(input int round, input des_mode_e mode);
        int amount;
        amount = (round == 1 || round == 2 || round == 9 || round == 16) ? 1 : 2;
        if (mode == DES_ENCRYPT) begin
            return amount;
        end
        // decryption starts from K16, which equals the unrotated C0/D0
        if (round == 1) begin
            return 0;
        end
        return -amount;
    endfunction

endpackage

// ==== design/des_input_stage.sv ====
// DES input stage
// initial permutation and PC1, registered with valid and mode

`timescale 1ns/1ps

`include "des_defs.svh"

module des_input_stage (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                valid_i,
    input  des_pkg::des_mode_e  mode_i,
    input  des_pkg::block_t     key_i,
    input  des_pkg::block_t     data_i,
    output logic                accept_o,
    output logic                valid_o,
    output des_pkg::des_mode_e  mode_o,
    output des_pkg::half_t      l_o,
    output des_pkg::half_t      r_o,
    output des_pkg::cd_t        c_o,
    output des_pkg::cd_t        d_o
);

    des_pkg::block_t ip_data;

    assign ip_data = des_pkg::ip_perm(data_i);

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            accept_o <= 1'b0;
            valid_o  <= 1'b0;
            mode_o   <= des_pkg::DES_ENCRYPT;
            l_o      <= '0;
            r_o      <= '0;
            c_o      <= '0;
            d_o      <= '0;
        end else begin
            // pipeline never stalls, so always ready once out of reset
            accept_o <= 1'b1;
            valid_o  <= valid_i;
            mode_o   <= mode_i;
            l_o      <= ip_data[0 +: `DES_HALF_W];
            r_o      <= ip_data[`DES_HALF_W +: `DES_HALF_W];
            c_o      <= des_pkg::pc1_c(key_i);
            d_o      <= des_pkg::pc1_d(key_i);
        end
    end

    // blocks are taken unconditionally, so a strobe must carry real data
    a_input_known: assert property (@(posedge clk_i) disable iff (!reset_i)
        valid_i |-> !$isunknown({data_i, key_i}))
        else $error("X on data_i or key_i with valid_i high");

endmodule

// ==== design/des_round.sv ====
// one DES Feistel round with its own slice of the key schedule
// C/D rotation, PC2 subkey, Feistel mix and one register stage

`timescale 1ns/1ps

`include "des_defs.svh"

module des_round #(
    parameter int ROUND = 1
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                valid_i,
    input  des_pkg::des_mode_e  mode_i,
    input  des_pkg::half_t      l_i,
    input  des_pkg::half_t      r_i,
    input  des_pkg::cd_t        c_i,
    input  des_pkg::cd_t        d_i,
    output logic                valid_o,
    output des_pkg::des_mode_e  mode_o,
    output des_pkg::half_t      l_o,
    output des_pkg::half_t      r_o,
    output des_pkg::cd_t        c_o,
    output des_pkg::cd_t        d_o
);

    // rotation amounts fixed per round, direction from the block's mode
    localparam int ENC_ROT = des_pkg::round_shift(ROUND, des_pkg::DES_ENCRYPT);
    localparam int DEC_ROT = -des_pkg::round_shift(ROUND, des_pkg::DES_DECRYPT);

    des_pkg::cd_t    c_rot;
    des_pkg::cd_t    d_rot;
    des_pkg::subkey_t subkey;

    // index 0 is the MSB, so << moves bits towards index 0
    always_comb begin
        if (mode_i == des_pkg::DES_DECRYPT) begin
            c_rot = (c_i >> DEC_ROT) | (c_i << (`DES_CD_W - DEC_ROT));
            d_rot = (d_i >> DEC_ROT) | (d_i << (`DES_CD_W - DEC_ROT));
        end else begin
            c_rot = (c_i << ENC_ROT) | (c_i >> (`DES_CD_W - ENC_ROT));
            d_rot = (d_i << ENC_ROT) | (d_i >> (`DES_CD_W - ENC_ROT));
        end
    end

    assign subkey = des_pkg::pc2_perm(c_rot, d_rot);

    // ==================================================
    // round register
    // ==================================================
    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            valid_o <= 1'b0;
            mode_o  <= des_pkg::DES_ENCRYPT;
            l_o     <= '0;
            r_o     <= '0;
            c_o     <= '0;
            d_o     <= '0;
        end else begin
            valid_o <= valid_i;
            mode_o  <= mode_i;
            l_o     <= r_i;
            r_o     <= l_i ^ des_pkg::feistel_f(r_i, subkey);
            c_o     <= c_rot;
            d_o     <= d_rot;
        end
    end

    // mode travels with the block through every round
    a_mode_known: assert property (@(posedge clk_i) disable iff (!reset_i)
        valid_i |-> !$isunknown(mode_i))
        else $error("X on mode in round %0d with valid high", ROUND);

endmodule

// ==== design/des_output_stage.sv ====
// DES output stage
// half swap, final permutation, registered result and valid

`timescale 1ns/1ps

module des_output_stage (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             valid_i,
    input  des_pkg::half_t   l_i,
    input  des_pkg::half_t   r_i,
    output des_pkg::block_t  data_o,
    output logic             valid_o
);

    des_pkg::block_t fp_data;

    // R16 goes first, undoing the swap of the last round
    assign fp_data = des_pkg::fp_perm({r_i, l_i});

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else begin
            valid_o <= valid_i;
            // last result stays visible through gaps
            if (valid_i) begin
                data_o <= fp_data;
            end
        end
    end

    // valid has to be clean all the way from valid_i through every stage
    a_valid_known: assert property (@(posedge clk_i) disable iff (!reset_i)
        !$isunknown(valid_o))
        else $error("valid_o is X after reset");

endmodule

// ==== design/des_pipeline.sv ====
// DES pipeline top level
// input stage, sixteen round stages and output stage
// one block per clock, no back-pressure

`timescale 1ns/1ps

`include "des_defs.svh"

module des_pipeline (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                valid_i,
    input  des_pkg::des_mode_e  mode_i,
    input  des_pkg::block_t     key_i,
    input  des_pkg::block_t     data_i,
    output logic                accept_o,
    output des_pkg::block_t     data_o,
    output logic                valid_o
);

    // ==================================================
    // stage buses, index 0 from the input stage
    // index n from round n
    // ==================================================
    logic               valid_s [0:`DES_ROUNDS];
    des_pkg::des_mode_e mode_s  [0:`DES_ROUNDS];
    des_pkg::half_t     l_s     [0:`DES_ROUNDS];
    des_pkg::half_t     r_s     [0:`DES_ROUNDS];
    des_pkg::cd_t       c_s     [0:`DES_ROUNDS];
    des_pkg::cd_t       d_s     [0:`DES_ROUNDS];

    des_input_stage u_input (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .valid_i  (valid_i),
        .mode_i   (mode_i),
        .key_i    (key_i),
        .data_i   (data_i),
        .accept_o (accept_o),
        .valid_o  (valid_s[0]),
        .mode_o   (mode_s[0]),
        .l_o      (l_s[0]),
        .r_o      (r_s[0]),
        .c_o      (c_s[0]),
        .d_o      (d_s[0])
    );

    for (genvar i = 1; i <= `DES_ROUNDS; i++) begin : g_round
        des_round #(
            .ROUND (i)
        ) u_round (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .valid_i (valid_s[i-1]),
            .mode_i  (mode_s[i-1]),
            .l_i     (l_s[i-1]),
            .r_i     (r_s[i-1]),
            .c_i     (c_s[i-1]),
            .d_i     (d_s[i-1]),
            .valid_o (valid_s[i]),
            .mode_o  (mode_s[i]),
            .l_o     (l_s[i]),
            .r_o     (r_s[i]),
            .c_o     (c_s[i]),
            .d_o     (d_s[i])
        );
    end

    // mode and key halves of the last round are not needed past here
    des_output_stage u_output (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_s[`DES_ROUNDS]),
        .l_i     (l_s[`DES_ROUNDS]),
        .r_i     (r_s[`DES_ROUNDS]),
        .data_o  (data_o),
        .valid_o (valid_o)
    );

endmodule

// ==== sim/des_tb_tasks.svh ====
// directed tests for the DES pipeline
// check and drive helpers, reset, known vectors, streaming, mixed traffic

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("test %s: %0d checks, %0d errors", name, check_count - c0, error_count - e0);
    endtask

    // drives one slot of stimulus and returns its cycle
    task automatic drive_block(input bit valid, input bit dec, input des_pkg::block_t key,
                               input des_pkg::block_t data, output int cycle);
        @(negedge clk_i);
        valid_i = valid;
        mode_i  = des_pkg::des_mode_e'(dec);
        key_i   = key;
        data_i  = data;
        cycle   = cycle_count;
    endtask

    task automatic drive_idle();
        @(negedge clk_i);
        valid_i = 1'b0;
    endtask

    task automatic clear_outputs();
        out_data_q.delete();
        out_cycle_q.delete();
    endtask

    task automatic wait_outputs(input int n);
        while (out_data_q.size() < n) begin
            @(negedge clk_i);
        end
    endtask

    task automatic reset_test();
        int c0;
        int e0;
        c0 = check_count;
        e0 = error_count;
        repeat (RESET_CYCLES) begin
            @(negedge clk_i);
            compare_value("valid_o in reset", 64'(valid_o), 64'd0);
            compare_value("accept_o in reset", 64'(accept_o), 64'd0);
            compare_value("data_o in reset", data_o, 64'd0);
        end
        reset_i = 1'b1;
        @(negedge clk_i);
        compare_value("accept_o after reset", 64'(accept_o), 64'd1);
        report_test("reset", c0, e0);
    endtask

    task automatic known_vector_test(input bit dec);
        int c0;
        int e0;
        int base;
        int cyc [2];
        c0   = check_count;
        e0   = error_count;
        base = dec ? 2 : 0;
        clear_outputs();
        for (int i = 0; i < 2; i++) begin
            drive_block(1'b1, dec, VEC_KEY[base+i], VEC_IN[base+i], cyc[i]);
        end
        drive_idle();
        wait_outputs(2);
        for (int i = 0; i < 2; i++) begin
            compare_value("vector result", out_data_q[i], VEC_OUT[base+i]);
            compare_value("vector latency", 64'(out_cycle_q[i] - cyc[i]), 64'(LAT));
        end
        report_test(dec ? "decrypt vectors" : "encrypt vectors", c0, e0);
    endtask

    task automatic stream_round_trip_test();
        int c0;
        int e0;
        int cyc;
        int first;
        des_pkg::block_t keys  [STREAM_N];
        des_pkg::block_t plain [STREAM_N];
        des_pkg::block_t cipher [STREAM_N];
        c0 = check_count;
        e0 = error_count;
        first = 0;
        for (int i = 0; i < STREAM_N; i++) begin
            keys[i]  = {next_random(), next_random()};
            plain[i] = {next_random(), next_random()};
        end
        clear_outputs();
        for (int i = 0; i < STREAM_N; i++) begin
            drive_block(1'b1, 1'b0, keys[i], plain[i], cyc);
            if (i == 0) begin
                first = cyc;
            end
        end
        drive_idle();
        wait_outputs(STREAM_N);
        for (int i = 0; i < STREAM_N; i++) begin
            cipher[i] = out_data_q[i];
            compare_value("stream encrypt latency", 64'(out_cycle_q[i] - first - i), 64'(LAT));
        end

        // ciphertexts go back in with the same keys
        clear_outputs();
        for (int i = 0; i < STREAM_N; i++) begin
            drive_block(1'b1, 1'b1, keys[i], cipher[i], cyc);
            if (i == 0) begin
                first = cyc;
            end
        end
        drive_idle();
        wait_outputs(STREAM_N);
        for (int i = 0; i < STREAM_N; i++) begin
            compare_value("round trip plaintext", out_data_q[i], plain[i]);
            compare_value("stream decrypt latency", 64'(out_cycle_q[i] - first - i), 64'(LAT));
        end
        report_test("stream round trip", c0, e0);
    endtask

    task automatic mixed_mode_test();
        int c0;
        int e0;
        int sel;
        int cyc;
        int last;
        logic [31:0] r;
        bit              slot_valid [MIX_SLOTS];
        int              slot_cycle [MIX_SLOTS];
        des_pkg::block_t slot_exp   [MIX_SLOTS];
        c0 = check_count;
        e0 = error_count;
        for (int s = 0; s < MIX_SLOTS; s++) begin
            r = next_random();
            // first slot valid so every gap has a known result to hold
            slot_valid[s] = (s == 0) || ((r % 3) != 0);
            sel = int'(next_random() % 4);
            if (slot_valid[s]) begin
                drive_block(1'b1, VEC_DEC[sel], VEC_KEY[sel], VEC_IN[sel], cyc);
                slot_exp[s] = VEC_OUT[sel];
            end else begin
                // junk on the bus during a bubble
                drive_block(1'b0, r[0], {next_random(), r}, {r, next_random()}, cyc);
                slot_exp[s] = slot_exp[s-1];
            end
            slot_cycle[s] = cyc;
        end
        drive_idle();
        last = slot_cycle[MIX_SLOTS-1] + LAT;
        while (cycle_count <= last) begin
            @(negedge clk_i);
        end
        for (int s = 0; s < MIX_SLOTS; s++) begin
            cyc = slot_cycle[s] + LAT;
            compare_value("valid_o pattern", 64'(valid_hist[cyc]), 64'(slot_valid[s]));
            if (slot_valid[s]) begin
                compare_value("mixed result", data_hist[cyc], slot_exp[s]);
            end else begin
                compare_value("data_o in gap", data_hist[cyc], slot_exp[s]);
            end
        end
        report_test("mixed modes", c0, e0);
    endtask

// ==== sim/des_tb.sv ====
// testbench top for the DES pipeline
// clock, reset, cycle counter and timeout
// output monitor, xorshift source, check counters and test sequence

`timescale 1ns/1ps

`include "des_defs.svh"

module des_tb;

    localparam int LAT          = `DES_LATENCY;
    localparam int RESET_CYCLES = 8;
    localparam int STREAM_N     = 20;
    localparam int MIX_SLOTS    = 24;

    // cycle budget of each test
    localparam int T_RESET  = RESET_CYCLES + 4;
    localparam int T_KNOWN  = 2 + LAT + 4;
    localparam int T_STREAM = 2 * (STREAM_N + LAT + 4);
    localparam int T_MIXED  = MIX_SLOTS + LAT + 4;
    localparam int TIMEOUT_CYCLES = 5 * (T_RESET + 2 * T_KNOWN + T_STREAM + T_MIXED);
    localparam int HIST_N = TIMEOUT_CYCLES + 2;

    // ==================================================
    // known vectors
    // ==================================================
    localparam des_pkg::block_t KEY_A    = 64'h133457799BBCDFF1;
    localparam des_pkg::block_t PLAIN_A  = 64'h0123456789ABCDEF;
    localparam des_pkg::block_t CIPHER_A = 64'h85E813540F0AB405;
    localparam des_pkg::block_t KEY_B    = 64'h0000000000000000;
    localparam des_pkg::block_t PLAIN_B  = 64'h0000000000000000;
    localparam des_pkg::block_t CIPHER_B = 64'h8CA64DE9C1B123A7;

    // entries 0 and 1 encrypt, 2 and 3 decrypt
    localparam des_pkg::block_t VEC_KEY [4] = '{KEY_A, KEY_B, KEY_A, KEY_B};
    localparam des_pkg::block_t VEC_IN  [4] = '{PLAIN_A, PLAIN_B, CIPHER_A, CIPHER_B};
    localparam des_pkg::block_t VEC_OUT [4] = '{CIPHER_A, CIPHER_B, PLAIN_A, PLAIN_B};
    localparam bit              VEC_DEC [4] = '{1'b0, 1'b0, 1'b1, 1'b1};

    logic               clk_i;
    logic               reset_i;
    logic               valid_i;
    des_pkg::des_mode_e mode_i;
    des_pkg::block_t    key_i;
    des_pkg::block_t    data_i;
    logic               accept_o;
    des_pkg::block_t    data_o;
    logic               valid_o;

    int          cycle_count = 0;
    int          check_count;
    int          error_count;
    logic [31:0] rng_state;

    // outputs seen at each falling edge, indexed by cycle
    logic            valid_hist [HIST_N];
    des_pkg::block_t data_hist  [HIST_N];
    des_pkg::block_t out_data_q [$];
    int              out_cycle_q [$];

    des_pipeline uut (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .valid_i  (valid_i),
        .mode_i   (mode_i),
        .key_i    (key_i),
        .data_i   (data_i),
        .accept_o (accept_o),
        .data_o   (data_o),
        .valid_o  (valid_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    // outputs are registered on the rising edge, so sample on the falling one
    always @(negedge clk_i) begin
        if (cycle_count < HIST_N) begin
            valid_hist[cycle_count] = valid_o;
            data_hist[cycle_count]  = data_o;
        end
        if (reset_i && valid_o === 1'b1) begin
            out_data_q.push_back(data_o);
            out_cycle_q.push_back(cycle_count);
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    `include "des_tb_tasks.svh"

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
        end
        $display("timeout: run stopped after %0d cycles before the tests finished", cycle_count);
        $display("Checks failed");
        $finish;
    end

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        clk_i       = 1'b0;
        reset_i     = 1'b0;
        valid_i     = 1'b0;
        mode_i      = des_pkg::DES_ENCRYPT;
        key_i       = '0;
        data_i      = '0;
        rng_state   = 32'hd09afec9;
        check_count = 0;
        error_count = 0;

        reset_test();
        known_vector_test(1'b0);
        known_vector_test(1'b1);
        stream_round_trip_test();
        mixed_mode_test();

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
+incdir+sim
design/des_pkg.sv
design/des_input_stage.sv
design/des_round.sv
design/des_output_stage.sv
design/des_pipeline.sv
sim/des_tb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the DES pipeline

VERILATOR   ?= verilator
FILELIST    ?= project.f
TB_TOP      ?= des_tb
RTL_TOP     ?= des_pipeline
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
FAIL_TEXT   ?= Checks failed
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
